/* verilog/rv_pkg.sv */
//--------------------------------------------------------------------
// Shared types for the RV32I subset core. CSR map covers the GPIO pair
//--------------------------------------------------------------------
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [11:0] CSR_GPIO_IN  = 12'hF00;  // Read only
    localparam logic [11:0] CSR_GPIO_OUT = 12'hF02;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU   = 2'd0,
        CSR   = 2'd1,
        IMM_U = 2'd2,
        LINK  = 2'd3
    } wb_sel_e;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;       // Also shamt for shift immediates
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;      // Also the CSR address
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_t;

    typedef struct packed {
        alu_op_e         alu_op;
        logic            use_imm;
        logic            reg_write;
        wb_sel_e         wb_sel;
        logic            branch;
        logic            jal;
        logic            jalr;
        logic            csr_en;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] imm;      // I, B, J or shamt, whichever applies
        logic [XLEN-1:0] imm_u;
        logic [11:0]     csr_addr;
    } ctrl_t;

endpackage

`default_nettype wire

/* verilog/csr_if.sv */
//--------------------------------------------------------------------
// CSR request from execute, answered combinationally in the same cycle
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface csr_if;

    logic                    csr_en;     // Valid CSRRW in execute
    logic [11:0]             csr_addr;
    logic [rv_pkg::XLEN-1:0] wdata;      // Forwarded rs1
    logic [rv_pkg::XLEN-1:0] rdata;

    modport requester (
        output csr_en,
        output csr_addr,
        output wdata,
        input  rdata
    );

    modport responder (
        input  csr_en,
        input  csr_addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* verilog/fetch_stage.sv */
//--------------------------------------------------------------------
// Word-addressed pc. A redirect costs exactly one bubble
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
    parameter int PC_WIDTH = 12
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                redirect,
    input  logic [PC_WIDTH-1:0] target,
    output logic [PC_WIDTH-1:0] imem_addr,
    input  logic [31:0]         imem_data,
    output rv_pkg::instr_t      ex_instr,
    output logic [PC_WIDTH-1:0] ex_pc,
    output logic                ex_valid
);

    logic [PC_WIDTH-1:0] pc;

    assign imem_addr = pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc       <= '0;
            ex_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc       <= target;
                ex_valid <= 1'b0;          // Squash the word fetched this cycle
            end else begin
                pc       <= pc + 1'b1;
                ex_valid <= 1'b1;
            end
        end
    end

    // Fetch-to-execute payload, qualified by ex_valid
    always_ff @(posedge clk) begin
        ex_instr <= rv_pkg::instr_t'(imem_data);
        ex_pc    <= pc;
    end

endmodule

`default_nettype wire

/* verilog/decode_ctrl.sv */
//--------------------------------------------------------------------
// Only CSRRW is decoded from SYSTEM; other unknown words do nothing
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module decode_ctrl (
    input  rv_pkg::instr_t instr,
    output rv_pkg::ctrl_t  ctrl
);

    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_j;
    logic [rv_pkg::XLEN-1:0] shamt;
    logic                    is_shift;
    logic                    alt_op;    // funct7 bit 5 selects SUB / SRA
    rv_pkg::alu_op_e         alu_op;

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};
    assign shamt = {27'd0, instr.r.rs2};

    assign is_shift = (instr.r.funct3 == 3'b001) || (instr.r.funct3 == 3'b101);
    assign alt_op   = instr.r.funct7[5];

    always_comb begin
        case (instr.r.funct3)
            3'b000: begin
                // No SUBI, so only register form uses funct7
                if ((instr.r.opcode == rv_pkg::OP) && alt_op)
                    alu_op = rv_pkg::SUB;
                else
                    alu_op = rv_pkg::ADD;
            end
            3'b001:  alu_op = rv_pkg::SLL;
            3'b010:  alu_op = rv_pkg::SLT;
            3'b011:  alu_op = rv_pkg::SLTU;
            3'b100:  alu_op = rv_pkg::XOR;
            3'b101: begin
                if (alt_op)
                    alu_op = rv_pkg::SRA;
                else
                    alu_op = rv_pkg::SRL;
            end
            3'b110:  alu_op = rv_pkg::OR;
            default: alu_op = rv_pkg::AND;
        endcase
    end

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = alu_op;
        ctrl.wb_sel   = rv_pkg::ALU;
        ctrl.funct3   = instr.r.funct3;
        ctrl.rd       = instr.r.rd;
        ctrl.rs1      = instr.r.rs1;
        ctrl.rs2      = instr.r.rs2;
        ctrl.imm_u    = {instr.u.imm, 12'd0};
        ctrl.csr_addr = instr.i.imm;

        case (instr.r.opcode)
            rv_pkg::OP: ctrl.reg_write = 1'b1;
            rv_pkg::OP_IMM: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.imm       = is_shift ? shamt : imm_i;
            end
            rv_pkg::LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::IMM_U;
            end
            rv_pkg::BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.imm    = imm_b;
            end
            rv_pkg::JAL: begin
                ctrl.jal       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::LINK;
                ctrl.imm       = imm_j;
            end
            rv_pkg::JALR: begin
                ctrl.jalr      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::LINK;
                ctrl.imm       = imm_i;
            end
            rv_pkg::SYSTEM: begin
                if (instr.i.funct3 == 3'b001) begin   // CSRRW
                    ctrl.csr_en    = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = rv_pkg::CSR;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
//--------------------------------------------------------------------
// Reads are combinational. Same-cycle write is not bypassed here
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [rv_pkg::XLEN-1:0] rdata1,
    output logic [rv_pkg::XLEN-1:0] rdata2,
    input  logic                    wb_we,
    input  logic [4:0]              wb_rd,
    input  logic [rv_pkg::XLEN-1:0] wb_data
);

    logic [rv_pkg::XLEN-1:0] regs [32];

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_we && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;       // x0 stays zero
        end
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
//--------------------------------------------------------------------
// Forwarding covers writeback only. PC_WIDTH+2 must not exceed XLEN
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int PC_WIDTH = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ex_valid,
    input  logic [PC_WIDTH-1:0]     ex_pc,
    input  rv_pkg::ctrl_t           ctrl,
    input  logic [rv_pkg::XLEN-1:0] rdata1,
    input  logic [rv_pkg::XLEN-1:0] rdata2,
    output logic                    redirect,
    output logic [PC_WIDTH-1:0]     target,
    output logic                    wb_we,
    output logic [4:0]              wb_rd,
    output logic [rv_pkg::XLEN-1:0] wb_data,
    csr_if.requester                csr
);

    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic                    taken;
    logic [rv_pkg::XLEN-1:0] pc_bytes;
    logic [rv_pkg::XLEN-1:0] rel_bytes;
    logic [rv_pkg::XLEN-1:0] jalr_bytes;
    logic [rv_pkg::XLEN-1:0] tgt_bytes;
    rv_pkg::wb_sel_e         wb_sel_q;
    logic [rv_pkg::XLEN-1:0] alu_q;
    logic [rv_pkg::XLEN-1:0] csr_q;
    logic [rv_pkg::XLEN-1:0] imm_u_q;
    logic [rv_pkg::XLEN-1:0] link_q;

    // Writeback result beats the register file
    assign rs1_val = (wb_we && (wb_rd != 5'd0) && (wb_rd == ctrl.rs1)) ? wb_data : rdata1;
    assign rs2_val = (wb_we && (wb_rd != 5'd0) && (wb_rd == ctrl.rs2)) ? wb_data : rdata2;

    assign op_b = ctrl.use_imm ? ctrl.imm : rs2_val;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::SUB:  alu_res = rs1_val - op_b;
            rv_pkg::AND:  alu_res = rs1_val & op_b;
            rv_pkg::OR:   alu_res = rs1_val | op_b;
            rv_pkg::XOR:  alu_res = rs1_val ^ op_b;
            rv_pkg::SLL:  alu_res = rs1_val << op_b[4:0];
            rv_pkg::SRL:  alu_res = rs1_val >> op_b[4:0];
            rv_pkg::SRA:  alu_res = $signed(rs1_val) >>> op_b[4:0];
            rv_pkg::SLT:  alu_res = {31'd0, $signed(rs1_val) < $signed(op_b)};
            rv_pkg::SLTU: alu_res = {31'd0, rs1_val < op_b};
            default:      alu_res = rs1_val + op_b;
        endcase
    end

    always_comb begin
        case (ctrl.funct3)
            3'b000:  taken = (rs1_val == rs2_val);                    // BEQ
            3'b001:  taken = (rs1_val != rs2_val);                    // BNE
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));   // BLT
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));  // BGE
            3'b110:  taken = (rs1_val < rs2_val);                     // BLTU
            3'b111:  taken = (rs1_val >= rs2_val);                    // BGEU
            default: taken = 1'b0;
        endcase
    end

    // Targets are formed in bytes, then cut back to a word address
    assign pc_bytes   = rv_pkg::XLEN'({ex_pc, 2'b00});
    assign rel_bytes  = pc_bytes + ctrl.imm;             // Branch and JAL
    assign jalr_bytes = (rs1_val + ctrl.imm) & ~32'd1;
    assign tgt_bytes  = ctrl.jalr ? jalr_bytes : rel_bytes;
    assign target     = tgt_bytes[PC_WIDTH+1:2];

    assign redirect = ex_valid && ((ctrl.branch && taken) || ctrl.jal || ctrl.jalr);

    assign csr.csr_en   = ex_valid && ctrl.csr_en;
    assign csr.csr_addr = ctrl.csr_addr;
    assign csr.wdata    = rs1_val;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            wb_we <= 1'b0;
        else
            wb_we <= ex_valid && ctrl.reg_write;
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ctrl.rd;
        wb_sel_q <= ctrl.wb_sel;
        alu_q    <= alu_res;
        csr_q    <= csr.rdata;
        imm_u_q  <= ctrl.imm_u;
        link_q   <= pc_bytes + 32'd4;
    end

    always_comb begin
        case (wb_sel_q)
            rv_pkg::CSR:   wb_data = csr_q;
            rv_pkg::IMM_U: wb_data = imm_u_q;
            rv_pkg::LINK:  wb_data = link_q;
            default:       wb_data = alu_q;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/csr_io.sv */
//--------------------------------------------------------------------
// GPIO CSRs. A write lands one cycle after its request is seen
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module csr_io (
    input  logic                    clk,
    input  logic                    rst,
    csr_if.responder                csr,
    input  logic [rv_pkg::XLEN-1:0] gpio_in,
    output logic [rv_pkg::XLEN-1:0] gpio_out
);

    logic                    pend_we;     // Write to 0xF02 sitting in writeback
    logic [rv_pkg::XLEN-1:0] pend_data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pend_we  <= 1'b0;
            gpio_out <= '0;
        end else begin
            pend_we <= csr.csr_en && (csr.csr_addr == rv_pkg::CSR_GPIO_OUT);
            if (pend_we)
                gpio_out <= pend_data;
        end
    end

    always_ff @(posedge clk) begin
        pend_data <= csr.wdata;
    end

    always_comb begin
        case (csr.csr_addr)
            rv_pkg::CSR_GPIO_IN:  csr.rdata = gpio_in;
            rv_pkg::CSR_GPIO_OUT: csr.rdata = pend_we ? pend_data : gpio_out;  // Bypass
            default:              csr.rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
//--------------------------------------------------------------------
// Three-stage RV32I subset core. imem_data must return in the same cycle
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter int PC_WIDTH = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [PC_WIDTH-1:0]     imem_addr,   // Word address
    input  logic [31:0]             imem_data,
    input  logic [rv_pkg::XLEN-1:0] gpio_in,
    output logic [rv_pkg::XLEN-1:0] gpio_out
);

    logic                    redirect;
    logic [PC_WIDTH-1:0]     target;
    rv_pkg::instr_t          ex_instr;
    logic [PC_WIDTH-1:0]     ex_pc;
    logic                    ex_valid;
    rv_pkg::ctrl_t           ctrl;
    logic [rv_pkg::XLEN-1:0] rdata1;
    logic [rv_pkg::XLEN-1:0] rdata2;
    logic                    wb_we;
    logic [4:0]              wb_rd;
    logic [rv_pkg::XLEN-1:0] wb_data;

    csr_if csr_bus ();

    fetch_stage #(.PC_WIDTH(PC_WIDTH)) fetch_i (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .target    (target),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .ex_instr  (ex_instr),
        .ex_pc     (ex_pc),
        .ex_valid  (ex_valid)
    );

    decode_ctrl decode_i (
        .instr (ex_instr),
        .ctrl  (ctrl)
    );

    regfile regfile_i (
        .clk     (clk),
        .rst     (rst),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

    execute_stage #(.PC_WIDTH(PC_WIDTH)) execute_i (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_pc    (ex_pc),
        .ctrl     (ctrl),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .redirect (redirect),
        .target   (target),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .csr      (csr_bus.requester)
    );

    csr_io csr_io_i (
        .clk      (clk),
        .rst      (rst),
        .csr      (csr_bus.responder),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

endmodule

`default_nettype wire

/* bench/tb_rv_core.sv */
//--------------------------------------------------------------------
// Random program of 256 words with forward control flow only
// gpio_out changes are checked against an instruction-set model
//--------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int          PC_WIDTH      = 12;
    localparam int          PROG_WORDS    = 256;
    localparam int          TIMEOUT       = 20000;
    localparam logic [31:0] HALT          = 32'h0000_006F;   // jal x0, 0
    localparam logic [6:0]  OPC_OP        = 7'b0110011;
    localparam logic [6:0]  OPC_IMM       = 7'b0010011;
    localparam logic [6:0]  OPC_LUI       = 7'b0110111;
    localparam logic [6:0]  OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0]  OPC_JAL       = 7'b1101111;
    localparam logic [6:0]  OPC_JALR      = 7'b1100111;
    localparam logic [6:0]  OPC_SYSTEM    = 7'b1110011;
    localparam logic [11:0] GPIO_IN_ADDR  = 12'hF00;
    localparam logic [11:0] GPIO_OUT_ADDR = 12'hF02;

    logic                clk;
    logic                rst;
    logic [PC_WIDTH-1:0] imem_addr;
    logic [31:0]         imem_data;
    logic [31:0]         gpio_in;
    logic [31:0]         gpio_out;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] lfsr;
    int          pos;
    int          halt_pc;
    logic [31:0] gpio_val;
    logic [31:0] writes[$];      // Every value the model writes to 0xF02
    logic [31:0] expect_q[$];    // Same values with repeats removed

    rv_core #(.PC_WIDTH(PC_WIDTH)) rv_core_i (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

    // Beyond the program the fetch port returns the halt loop
    assign imem_data = (imem_addr[PC_WIDTH-1:8] == '0) ? prog[imem_addr[7:0]] : HALT;

    always #50 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(1 + random_bits(4) % 15);    // x1 to x15
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] ofs);
        return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] ofs);
        return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] csrrw_word(input logic [4:0] rd, input logic [11:0] csr,
                                               input logic [4:0] rs1);
        return i_type(csr, rs1, 3'b001, rd, OPC_SYSTEM);
    endfunction

    task automatic put_word(input logic [31:0] w);
        prog[pos[7:0]] = w;
        pos++;
    endtask

    // Dependent ALU chain, result sent to the output port
    task automatic alu_block();
        int         n;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] last;
        logic [2:0] f3;
        logic [1:0] kind;
        logic       alt;
        n    = 2 + int'(random_bits(2));
        last = pick_reg();
        for (int k = 0; k < n; k++) begin
            rd   = pick_reg();
            rs1  = (random_bits(1) != 0) ? last : 5'(random_bits(4));
            rs2  = (random_bits(1) != 0) ? last : 5'(random_bits(4));
            kind = 2'(random_bits(2));
            f3   = 3'(random_bits(3));
            alt  = 1'(random_bits(1)) && (f3 == 3'b000 || f3 == 3'b101);
            if (kind == 2'd0) begin
                put_word(r_type({1'b0, alt, 5'd0}, rs2, rs1, f3, rd, OPC_OP));
            end else if (kind == 2'd3) begin
                put_word(u_type(20'(random_bits(20)), rd));
            end else if (f3 == 3'b001 || f3 == 3'b101) begin
                put_word(i_type({1'b0, alt, 5'd0, 5'(random_bits(5))}, rs1, f3, rd, OPC_IMM));
            end else begin
                put_word(i_type(12'(random_bits(12)), rs1, f3, rd, OPC_IMM));
            end
            last = rd;
        end
        put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, last));
    endtask

    // Forward branch over marker writes; x26 and x27 are the operands
    task automatic branch_block();
        int         skip;
        logic [2:0] f3;
        logic [4:0] ra;
        skip = 1 + int'(random_bits(2) % 3);
        put_word(u_type(20'(random_bits(20)), 5'd26));
        put_word(i_type(12'(random_bits(12)), 5'd26, 3'b000, 5'd26, OPC_IMM));
        if (random_bits(1) != 0) begin
            put_word(i_type(12'd0, 5'd26, 3'b000, 5'd27, OPC_IMM));   // Equal operands
        end else begin
            put_word(u_type(20'(random_bits(20)), 5'd27));
            put_word(i_type(12'(random_bits(12)), 5'd27, 3'b000, 5'd27, OPC_IMM));
        end
        for (int k = 0; k < skip; k++) begin
            put_word(i_type(12'(random_bits(12)), 5'd0, 3'b000, 5'(28 + k), OPC_IMM));
        end
        case (random_bits(3) % 6)
            0:       f3 = 3'b000;
            1:       f3 = 3'b001;
            2:       f3 = 3'b100;
            3:       f3 = 3'b101;
            4:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        ra = (random_bits(1) != 0) ? 5'd26 : 5'd27;
        put_word(b_type(f3, ra, (ra == 5'd26) ? 5'd27 : 5'd26, 13'((skip + 1) * 4)));
        for (int k = 0; k < skip; k++) begin
            put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, 5'(28 + k)));
        end
        put_word(i_type(12'(random_bits(12)), 5'd0, 3'b000, 5'd31, OPC_IMM));
        put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, 5'd31));
    endtask

    // JAL, or JALR through x25, then the link value goes out
    task automatic jump_block(input logic use_jalr);
        int          skip;
        logic [4:0]  link;
        logic [3:0]  r;
        logic [11:0] ofs;
        logic [31:0] base;
        skip = 1 + int'(random_bits(2) % 3);
        link = 5'(16 + random_bits(3));
        if (use_jalr) begin
            r    = 4'(random_bits(4));
            ofs  = {{8{r[3]}}, r};
            base = 32'((pos + 2 + skip) * 4) - {{20{ofs[11]}}, ofs} + random_bits(1);
            put_word(i_type(base[11:0], 5'd0, 3'b000, 5'd25, OPC_IMM));
            put_word(i_type(ofs, 5'd25, 3'b000, link, OPC_JALR));
        end else begin
            put_word(j_type(link, 21'((skip + 1) * 4)));
        end
        for (int k = 0; k < skip; k++) begin
            put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, 5'(28 + k)));
        end
        put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, link));
    endtask

    task automatic csr_block();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rc;
        ra = pick_reg();
        put_word(csrrw_word(ra, GPIO_IN_ADDR, 5'd0));
        put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, ra));
        rb = pick_reg();
        rc = 5'(16 + random_bits(3));
        put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, rb));
        put_word(csrrw_word(rc, GPIO_OUT_ADDR, pick_reg()));   // rc gets rb's value
        put_word(csrrw_word(5'd0, GPIO_OUT_ADDR, rc));
    endtask

    task automatic build_program();
        for (int k = 0; k < PROG_WORDS; k++) begin
            prog[k] = HALT;
        end
        pos = 0;
        while (pos < PROG_WORDS - 16) begin
            case (3'(random_bits(3)))
                3'd0, 3'd1: alu_block();
                3'd2, 3'd3: branch_block();
                3'd4:       jump_block(1'b0);
                3'd5:       jump_block(1'b1);
                default:    csr_block();
            endcase
        end
        halt_pc = pos;
    endtask

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'd0, $signed(a) < $signed(b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Runs the program in order, pc in bytes
    task automatic run_model();
        logic [31:0] mregs [32];
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] res;
        logic [31:0] gpio;
        logic [31:0] imm_i;
        logic        wr;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            mregs[k] = '0;
        end
        pc    = '0;
        gpio  = '0;
        steps = 0;
        while (pc[31:2] != 30'(halt_pc)) begin
            assert (steps < 4 * PROG_WORDS) else
                stop_on_error("model did not reach the halt instruction");
            steps++;
            w     = prog[pc[9:2]];
            a     = mregs[w[19:15]];
            imm_i = {{20{w[31]}}, w[31:20]};
            res   = '0;
            wr    = 1'b0;
            next  = pc + 32'd4;
            case (w[6:0])
                OPC_OP: begin
                    res = ref_alu(w[14:12], w[30], a, mregs[w[24:20]]);
                    wr  = 1'b1;
                end
                OPC_IMM: begin
                    if (w[14:12] == 3'b001 || w[14:12] == 3'b101)
                        res = ref_alu(w[14:12], w[30], a, {27'd0, w[24:20]});
                    else
                        res = ref_alu(w[14:12], 1'b0, a, imm_i);
                    wr = 1'b1;
                end
                OPC_LUI: begin
                    res = {w[31:12], 12'd0};
                    wr  = 1'b1;
                end
                OPC_BRANCH: begin
                    if (branch_taken(w[14:12], a, mregs[w[24:20]]))
                        next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                OPC_JAL: begin
                    res  = pc + 32'd4;
                    wr   = 1'b1;
                    next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                OPC_JALR: begin
                    res  = pc + 32'd4;
                    wr   = 1'b1;
                    next = (a + imm_i) & ~32'd1;
                end
                OPC_SYSTEM: begin
                    if (w[14:12] == 3'b001) begin
                        if (w[31:20] == GPIO_IN_ADDR) begin
                            res = gpio_val;
                        end else if (w[31:20] == GPIO_OUT_ADDR) begin
                            res  = gpio;          // Old value, then the write
                            gpio = a;
                            writes.push_back(a);
                        end
                        wr = 1'b1;
                    end
                end
                default: ;
            endcase
            if (wr && (w[11:7] != 5'd0))
                mregs[w[11:7]] = res;
            pc = next;
        end
        gpio = '0;
        foreach (writes[k]) begin
            if (writes[k] != gpio) begin
                expect_q.push_back(writes[k]);
                gpio = writes[k];
            end
        end
    endtask

    initial begin
        int          cycles;
        int          halt_cycles;
        int          seen;
        logic [31:0] last_out;
        logic [31:0] final_val;
        clk     = 1'b0;
        rst     = 1'b0;
        gpio_in = '0;
        lfsr    = 32'h4571;
        gpio_val = random_bits(32);
        build_program();
        run_model();
        final_val = (writes.size() > 0) ? writes[writes.size() - 1] : 32'd0;

        @(posedge clk);
        gpio_in <= gpio_val;
        @(negedge clk);
        assert (gpio_out == 32'd0) else
            stop_on_error($sformatf("error: gpio_out = %h in reset, expected %h",
                                    gpio_out, 32'd0));
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        cycles      = 0;
        halt_cycles = 0;
        seen        = 0;
        last_out    = '0;
        while (halt_cycles < 8) begin
            @(negedge clk);
            if (cycles == 0) begin
                assert (imem_addr == '0) else
                    stop_on_error($sformatf("error: imem_addr = %h after reset, expected %h",
                                            imem_addr, 12'd0));
            end
            cycles++;
            assert (cycles <= TIMEOUT) else
                stop_on_error("timed out waiting for the core to reach the halt loop");
            if (gpio_out !== last_out) begin
                assert (seen < expect_q.size()) else
                    stop_on_error($sformatf("gpio_out changed to %h after the last model write",
                                            gpio_out));
                assert (gpio_out == expect_q[seen]) else
                    stop_on_error($sformatf("error: gpio_out = %h, expected %h",
                                            gpio_out, expect_q[seen]));
                seen++;
                last_out = gpio_out;
            end
            // Halt loop alternates between its own address and the next one
            if (int'(imem_addr) == halt_pc || int'(imem_addr) == halt_pc + 1)
                halt_cycles++;
            else
                halt_cycles = 0;
        end

        assert (seen == expect_q.size()) else
            stop_on_error($sformatf("only %0d of %0d expected gpio_out values appeared",
                                    seen, expect_q.size()));
        assert (gpio_out == final_val) else
            stop_on_error($sformatf("error: gpio_out = %h at the end, expected %h",
                                    gpio_out, final_val));
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/rv_pkg.sv
verilog/csr_if.sv
verilog/fetch_stage.sv
verilog/decode_ctrl.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/csr_io.sv
verilog/rv_core.sv
bench/tb_rv_core.sv

/* Makefile */
# Verilator build and run for the RV32I subset core and its testbench
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
SOURCES   := $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
